// ==== rtl/rv32_pkg.sv ====
package rv32_pkg;

    localparam int unsigned xlen = 32;

    typedef logic [4:0] reg_addr_t;

    // Immediate layouts, selected by the decoder
    typedef enum logic [2:0] {
        imm_none,
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j,
        imm_shamt
    } imm_fmt_e;

    // Same order as the funct3 field of OP and OP-IMM
    typedef enum logic [2:0] {
        alu_add_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl_sra,
        alu_or,
        alu_and
    } alu_op_e;

    typedef enum logic [1:0] {
        src1_reg,
        src1_pc,
        src1_zero
    } alu_src1_e;

    typedef enum logic [1:0] {
        src2_reg,
        src2_imm,
        src2_four
    } alu_src2_e;

    typedef enum logic [1:0] {
        mem_byte,
        mem_half,
        mem_word
    } mem_width_e;

    // Condition on the ALU result
    typedef enum logic [1:0] {
        br_never,
        br_zero,
        br_non_zero,
        br_always
    } branch_op_e;

    typedef enum logic {
        br_pc_imm,
        br_pc_reg
    } branch_pc_src_e;

    localparam logic [6:0] op_lui      = 7'b0110111;
    localparam logic [6:0] op_auipc    = 7'b0010111;
    localparam logic [6:0] op_jal      = 7'b1101111;
    localparam logic [6:0] op_jalr     = 7'b1100111;
    localparam logic [6:0] op_branch   = 7'b1100011;
    localparam logic [6:0] op_load     = 7'b0000011;
    localparam logic [6:0] op_store    = 7'b0100011;
    localparam logic [6:0] op_imm      = 7'b0010011;
    localparam logic [6:0] op_reg      = 7'b0110011;
    localparam logic [6:0] op_misc_mem = 7'b0001111;

    localparam logic [2:0] f3_jalr = 3'b000;

    // Branches
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // Loads and stores
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;
    localparam logic [2:0] f3_sb  = 3'b000;
    localparam logic [2:0] f3_sh  = 3'b001;
    localparam logic [2:0] f3_sw  = 3'b010;

    // ALU
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [2:0] f3_fence   = 3'b000;
    localparam logic [2:0] f3_fence_i = 3'b001;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    typedef struct packed {
        logic           legal;
        imm_fmt_e       imm_fmt;
        alu_op_e        alu_op;
        logic           alu_sub_sra;
        alu_src1_e      alu_src1;
        alu_src2_e      alu_src2;
        logic           mem_read;
        logic           mem_write;
        mem_width_e     mem_width;
        logic           mem_zero_extend;
        logic           mem_fence;
        branch_op_e     branch_op;
        branch_pc_src_e branch_pc_src;
        logic           rd_write;
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
    } fetch_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        ctrl_t           ctrl;
        logic [xlen-1:0] imm;
        reg_addr_t       rs1;
        reg_addr_t       rs2;
        reg_addr_t       rd;
    } decode_t;

endpackage

// ==== rtl/rv32_pipe_reg.sv ====
`timescale 1ns/10ps

module rv32_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    logic     full;
    payload_t data_q;

    // Take a new item when empty or when the current one leaves this cycle
    assign in_ready = !full || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = full;
    assign out_data  = data_q;
endmodule

// ==== rtl/rv32_control_unit.sv ====
`timescale 1ns/10ps

module rv32_control_unit (
    input  logic [rv32_pkg::xlen-1:0] instr,
    output rv32_pkg::ctrl_t           ctrl
);
    import rv32_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        ctrl = '0;

        case (opcode)
            op_lui: begin
                ctrl.legal    = 1'b1;
                ctrl.imm_fmt  = imm_u;
                ctrl.alu_src1 = src1_zero;
                ctrl.alu_src2 = src2_imm;
                ctrl.rd_write = 1'b1;
            end
            op_auipc: begin
                ctrl.legal    = 1'b1;
                ctrl.imm_fmt  = imm_u;
                ctrl.alu_src1 = src1_pc;
                ctrl.alu_src2 = src2_imm;
                ctrl.rd_write = 1'b1;
            end
            // Jumps write the link address pc + 4 through the ALU
            op_jal: begin
                ctrl.legal         = 1'b1;
                ctrl.imm_fmt       = imm_j;
                ctrl.alu_src1      = src1_pc;
                ctrl.alu_src2      = src2_four;
                ctrl.branch_op     = br_always;
                ctrl.branch_pc_src = br_pc_imm;
                ctrl.rd_write      = 1'b1;
            end
            op_jalr: begin
                ctrl.legal         = (funct3 == f3_jalr);
                ctrl.imm_fmt       = imm_i;
                ctrl.alu_src1      = src1_pc;
                ctrl.alu_src2      = src2_four;
                ctrl.branch_op     = br_always;
                ctrl.branch_pc_src = br_pc_reg;
                ctrl.rd_write      = 1'b1;
            end
            op_branch: begin
                ctrl.legal         = 1'b1;
                ctrl.imm_fmt       = imm_b;
                ctrl.alu_sub_sra   = 1'b1;
                ctrl.alu_src1      = src1_reg;
                ctrl.alu_src2      = src2_reg;
                ctrl.branch_pc_src = br_pc_imm;
                case (funct3)
                    f3_beq: begin
                        ctrl.alu_op    = alu_add_sub;
                        ctrl.branch_op = br_zero;
                    end
                    f3_bne: begin
                        ctrl.alu_op    = alu_add_sub;
                        ctrl.branch_op = br_non_zero;
                    end
                    f3_blt: begin
                        ctrl.alu_op    = alu_slt;
                        ctrl.branch_op = br_non_zero;
                    end
                    f3_bge: begin
                        ctrl.alu_op    = alu_slt;
                        ctrl.branch_op = br_zero;
                    end
                    f3_bltu: begin
                        ctrl.alu_op    = alu_sltu;
                        ctrl.branch_op = br_non_zero;
                    end
                    f3_bgeu: begin
                        ctrl.alu_op    = alu_sltu;
                        ctrl.branch_op = br_zero;
                    end
                    default: ctrl.legal = 1'b0;
                endcase
            end
            // Address is rs1 + imm for loads and stores
            op_load: begin
                ctrl.legal    = 1'b1;
                ctrl.imm_fmt  = imm_i;
                ctrl.alu_src1 = src1_reg;
                ctrl.alu_src2 = src2_imm;
                ctrl.mem_read = 1'b1;
                ctrl.rd_write = 1'b1;
                case (funct3)
                    f3_lb:  ctrl.mem_width = mem_byte;
                    f3_lh:  ctrl.mem_width = mem_half;
                    f3_lw:  ctrl.mem_width = mem_word;
                    f3_lbu: begin
                        ctrl.mem_width       = mem_byte;
                        ctrl.mem_zero_extend = 1'b1;
                    end
                    f3_lhu: begin
                        ctrl.mem_width       = mem_half;
                        ctrl.mem_zero_extend = 1'b1;
                    end
                    default: ctrl.legal = 1'b0;
                endcase
            end
            op_store: begin
                ctrl.legal     = 1'b1;
                ctrl.imm_fmt   = imm_s;
                ctrl.alu_src1  = src1_reg;
                ctrl.alu_src2  = src2_imm;
                ctrl.mem_write = 1'b1;
                case (funct3)
                    f3_sb:   ctrl.mem_width = mem_byte;
                    f3_sh:   ctrl.mem_width = mem_half;
                    f3_sw:   ctrl.mem_width = mem_word;
                    default: ctrl.legal = 1'b0;
                endcase
            end
            op_imm: begin
                ctrl.legal    = 1'b1;
                ctrl.imm_fmt  = imm_i;
                ctrl.alu_src1 = src1_reg;
                ctrl.alu_src2 = src2_imm;
                ctrl.rd_write = 1'b1;
                case (funct3)
                    f3_add_sub: ctrl.alu_op = alu_add_sub;
                    f3_slt: begin
                        ctrl.alu_op      = alu_slt;
                        ctrl.alu_sub_sra = 1'b1;
                    end
                    f3_sltu: begin
                        ctrl.alu_op      = alu_sltu;
                        ctrl.alu_sub_sra = 1'b1;
                    end
                    f3_xor: ctrl.alu_op = alu_xor;
                    f3_or:  ctrl.alu_op = alu_or;
                    f3_and: ctrl.alu_op = alu_and;
                    // Shift amount sits in the low imm bits, funct7 above it
                    f3_sll: begin
                        ctrl.legal   = (funct7 == f7_base);
                        ctrl.imm_fmt = imm_shamt;
                        ctrl.alu_op  = alu_sll;
                    end
                    f3_srl_sra: begin
                        ctrl.legal       = (funct7 == f7_base) || (funct7 == f7_alt);
                        ctrl.imm_fmt     = imm_shamt;
                        ctrl.alu_op      = alu_srl_sra;
                        ctrl.alu_sub_sra = (funct7 == f7_alt);
                    end
                    default: ctrl.legal = 1'b0;
                endcase
            end
            op_reg: begin
                ctrl.legal    = (funct7 == f7_base);
                ctrl.alu_src1 = src1_reg;
                ctrl.alu_src2 = src2_reg;
                ctrl.rd_write = 1'b1;
                case (funct3)
                    f3_add_sub: begin
                        ctrl.legal       = (funct7 == f7_base) || (funct7 == f7_alt);
                        ctrl.alu_op      = alu_add_sub;
                        ctrl.alu_sub_sra = (funct7 == f7_alt);
                    end
                    f3_sll: ctrl.alu_op = alu_sll;
                    f3_slt: begin
                        ctrl.alu_op      = alu_slt;
                        ctrl.alu_sub_sra = 1'b1;
                    end
                    f3_sltu: begin
                        ctrl.alu_op      = alu_sltu;
                        ctrl.alu_sub_sra = 1'b1;
                    end
                    f3_xor: ctrl.alu_op = alu_xor;
                    f3_srl_sra: begin
                        ctrl.legal       = (funct7 == f7_base) || (funct7 == f7_alt);
                        ctrl.alu_op      = alu_srl_sra;
                        ctrl.alu_sub_sra = (funct7 == f7_alt);
                    end
                    f3_or:   ctrl.alu_op = alu_or;
                    f3_and:  ctrl.alu_op = alu_and;
                    default: ctrl.legal = 1'b0;
                endcase
            end
            op_misc_mem: begin
                case (funct3)
                    f3_fence: ctrl.legal = 1'b1;
                    // FENCE.I has all other fields reserved as zero
                    f3_fence_i: begin
                        ctrl.legal     = (instr[31:15] == '0) && (instr[11:7] == '0);
                        ctrl.mem_fence = 1'b1;
                    end
                    default: ctrl.legal = 1'b0;
                endcase
            end
            default: ctrl.legal = 1'b0;
        endcase

        // Nothing but zeros for an unknown encoding
        if (!ctrl.legal) begin
            ctrl = '0;
        end
    end
endmodule

// ==== rtl/rv32_imm_gen.sv ====
`timescale 1ns/10ps

module rv32_imm_gen (
    input  logic [rv32_pkg::xlen-1:0] instr,
    input  rv32_pkg::imm_fmt_e        imm_fmt,
    output logic [rv32_pkg::xlen-1:0] imm
);
    import rv32_pkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_fmt)
            imm_i: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            imm_s: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            // Branch and jump offsets are in halfwords
            imm_b: begin
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            imm_u: begin
                imm = {instr[31:12], 12'b0};
            end
            imm_j: begin
                imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            imm_shamt: begin
                imm = {27'b0, instr[24:20]};
            end
            default: begin
                imm = '0;
            end
        endcase
    end
endmodule

// ==== rtl/rv32_decode_stage.sv ====
`timescale 1ns/10ps

module rv32_decode_stage (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              in_valid,
    output logic              in_ready,
    input  rv32_pkg::fetch_t  in_data,

    output logic              out_valid,
    input  logic              out_ready,
    output rv32_pkg::decode_t out_data
);
    import rv32_pkg::*;

    fetch_t          fetch_q;
    logic            fetch_valid;
    logic            fetch_ready;
    ctrl_t           ctrl;
    logic [xlen-1:0] imm;
    decode_t         decoded;

    rv32_pipe_reg #(
        .payload_t (fetch_t)
    ) u_fetch_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (fetch_valid),
        .out_ready (fetch_ready),
        .out_data  (fetch_q)
    );

    rv32_control_unit u_control (
        .instr (fetch_q.instr),
        .ctrl  (ctrl)
    );

    rv32_imm_gen u_imm_gen (
        .instr   (fetch_q.instr),
        .imm_fmt (ctrl.imm_fmt),
        .imm     (imm)
    );

    // Register fields sit at fixed positions in every format
    assign decoded.pc   = fetch_q.pc;
    assign decoded.ctrl = ctrl;
    assign decoded.imm  = imm;
    assign decoded.rs1  = fetch_q.instr[19:15];
    assign decoded.rs2  = fetch_q.instr[24:20];
    assign decoded.rd   = fetch_q.instr[11:7];

    rv32_pipe_reg #(
        .payload_t (decode_t)
    ) u_decode_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (fetch_valid),
        .in_ready  (fetch_ready),
        .in_data   (decoded),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );
endmodule

// ==== verif/rv32_decode_stage_tb.sv ====
`timescale 1ns/10ps

module rv32_decode_stage_tb;
    import rv32_pkg::*;

    localparam int words_per_vec = 17;
    localparam int max_vecs      = 64;
    localparam int reset_cycles  = 10;
    localparam int cycles_per_vec = 20;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    logic    in_ready;
    fetch_t  in_data;
    logic    out_valid;
    logic    out_ready;
    decode_t out_data;

    logic [31:0] vec_mem [0:words_per_vec*max_vecs-1];
    int          num_vecs;
    bit          loaded;
    bit          pass_done;
    int          cycle_count;
    int          in_cycles[$];

    rv32_decode_stage DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic check_equal(input string name, input logic [159:0] expected,
                               input logic [159:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            $display("Something failed");
            $fatal(1, "check failed");
        end
    endtask

    // Columns: pc, instr, 14 ctrl fields in struct order, imm
    function automatic decode_t expected_decode(input int idx);
        decode_t     d;
        int          b;
        logic [31:0] instr;
        b     = idx * words_per_vec;
        instr = vec_mem[b+1];
        d.pc                   = vec_mem[b];
        d.ctrl.legal           = vec_mem[b+2][0];
        d.ctrl.imm_fmt         = imm_fmt_e'(vec_mem[b+3][2:0]);
        d.ctrl.alu_op          = alu_op_e'(vec_mem[b+4][2:0]);
        d.ctrl.alu_sub_sra     = vec_mem[b+5][0];
        d.ctrl.alu_src1        = alu_src1_e'(vec_mem[b+6][1:0]);
        d.ctrl.alu_src2        = alu_src2_e'(vec_mem[b+7][1:0]);
        d.ctrl.mem_read        = vec_mem[b+8][0];
        d.ctrl.mem_write       = vec_mem[b+9][0];
        d.ctrl.mem_width       = mem_width_e'(vec_mem[b+10][1:0]);
        d.ctrl.mem_zero_extend = vec_mem[b+11][0];
        d.ctrl.mem_fence       = vec_mem[b+12][0];
        d.ctrl.branch_op       = branch_op_e'(vec_mem[b+13][1:0]);
        d.ctrl.branch_pc_src   = branch_pc_src_e'(vec_mem[b+14][0]);
        d.ctrl.rd_write        = vec_mem[b+15][0];
        d.imm                  = vec_mem[b+16];
        // Register fields at fixed positions in every format
        d.rs1 = instr[19:15];
        d.rs2 = instr[24:20];
        d.rd  = instr[11:7];
        return d;
    endfunction

    task automatic drive_vectors(input int pass_no);
        bit accepted;
        for (int i = 0; i < num_vecs; i++) begin
            // Occasional idle cycle in the stress pass
            if (pass_no == 2 && ($urandom % 4) == 0) begin
                in_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            in_data.pc    = vec_mem[i*words_per_vec];
            in_data.instr = vec_mem[i*words_per_vec+1];
            in_valid      = 1'b1;
            accepted      = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = in_ready;
                if (accepted) begin
                    in_cycles.push_back(cycle_count + 1);
                end
                @(posedge clk);
                #1;
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_outputs(input int pass_no);
        int      count;
        int      in_cycle;
        bit      held;
        decode_t held_data;
        string   name;
        count = 0;
        held  = 1'b0;
        while (count < num_vecs) begin
            @(negedge clk);
            name = $sformatf("pass%0d vec%0d", pass_no, count);
            if (held) begin
                check_equal({name, " stall valid"}, 1'b1, out_valid);
                check_equal({name, " stall hold"}, held_data, out_data);
            end
            if (out_valid && out_ready) begin
                check_equal({name, " decode"}, expected_decode(count), out_data);
                check_equal({name, " input order"}, 1'b1, in_cycles.size() != 0);
                in_cycle = in_cycles.pop_front();
                if (pass_no == 1) begin
                    check_equal({name, " latency"}, 2, cycle_count + 1 - in_cycle);
                end
                count++;
                held = 1'b0;
            end else if (out_valid) begin
                held      = 1'b1;
                held_data = out_data;
            end else begin
                held = 1'b0;
            end
        end
        pass_done = 1'b1;
    endtask

    task automatic randomize_ready();
        while (!pass_done) begin
            out_ready = $urandom % 2;
            @(posedge clk);
            #1;
        end
        out_ready = 1'b1;
    endtask

    initial begin
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_data     = '0;
        out_ready   = 1'b1;
        cycle_count = 0;
        pass_done   = 1'b0;
        loaded      = 1'b0;
        void'($urandom(7068));

        $readmemh("verif/decode_patterns.hex", vec_mem);
        num_vecs = 0;
        while (num_vecs < max_vecs && !$isunknown(vec_mem[num_vecs*words_per_vec])) begin
            num_vecs++;
        end
        if (num_vecs == 0) begin
            $display("No test vectors could be read from the pattern file");
            $display("Something failed");
            $fatal(1, "no vectors");
        end
        loaded = 1'b1;

        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_equal("reset out_valid", 1'b0, out_valid);
        check_equal("reset in_ready", 1'b1, in_ready);
        @(posedge clk);
        #1;

        // Pass 1 with downstream always ready
        fork
            drive_vectors(1);
            collect_outputs(1);
        join
        @(posedge clk);
        #1;

        // Pass 2 under random back-pressure
        pass_done = 1'b0;
        fork
            drive_vectors(2);
            collect_outputs(2);
            randomize_ready();
        join

        @(negedge clk);
        check_equal("extra output", 1'b0, out_valid);
        check_equal("leftover inputs", 0, in_cycles.size());
        $display("Everything OK");
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (reset_cycles + 2 * cycles_per_vec * num_vecs) @(posedge clk);
        $display("Timeout: decoded outputs stopped arriving");
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end
endmodule

// ==== verif/decode_patterns.hex ====
// pc instr | legal fmt alu sub src1 src2 mrd mwr width zext fence brop pcsrc rdw | imm
// rs1, rs2 and rd come from instr bits 19:15, 24:20 and 11:7
00001000 003100B3 1 0 0 0 0 0 0 0 0 0 0 0 0 1 00000000 // add
00001004 403100B3 1 0 0 1 0 0 0 0 0 0 0 0 0 1 00000000 // sub
00001008 003110B3 1 0 1 0 0 0 0 0 0 0 0 0 0 1 00000000 // sll
0000100C 003120B3 1 0 2 1 0 0 0 0 0 0 0 0 0 1 00000000 // slt
00001010 003130B3 1 0 3 1 0 0 0 0 0 0 0 0 0 1 00000000 // sltu
00001014 003140B3 1 0 4 0 0 0 0 0 0 0 0 0 0 1 00000000 // xor
00001018 003150B3 1 0 5 0 0 0 0 0 0 0 0 0 0 1 00000000 // srl
0000101C 403150B3 1 0 5 1 0 0 0 0 0 0 0 0 0 1 00000000 // sra
00001020 003160B3 1 0 6 0 0 0 0 0 0 0 0 0 0 1 00000000 // or
00001024 003170B3 1 0 7 0 0 0 0 0 0 0 0 0 0 1 00000000 // and
00001028 FFF30293 1 1 0 0 0 1 0 0 0 0 0 0 0 1 FFFFFFFF // addi -1
0000102C 00532293 1 1 2 1 0 1 0 0 0 0 0 0 0 1 00000005 // slti
00001030 7FF33293 1 1 3 1 0 1 0 0 0 0 0 0 0 1 000007FF // sltiu
00001034 80034293 1 1 4 0 0 1 0 0 0 0 0 0 0 1 FFFFF800 // xori -2048
00001038 12336293 1 1 6 0 0 1 0 0 0 0 0 0 0 1 00000123 // ori
0000103C 0FF37293 1 1 7 0 0 1 0 0 0 0 0 0 0 1 000000FF // andi
00001040 01F31293 1 6 1 0 0 1 0 0 0 0 0 0 0 1 0000001F // slli 31
00001044 00435293 1 6 5 0 0 1 0 0 0 0 0 0 0 1 00000004 // srli 4
00001048 40735293 1 6 5 1 0 1 0 0 0 0 0 0 0 1 00000007 // srai 7
0000104C 123453B7 1 4 0 0 2 1 0 0 0 0 0 0 0 1 12345000 // lui
00001050 FFFFF3B7 1 4 0 0 2 1 0 0 0 0 0 0 0 1 FFFFF000 // lui negative
00001054 00010417 1 4 0 0 1 1 0 0 0 0 0 0 0 1 00010000 // auipc
00001058 00458503 1 1 0 0 0 1 1 0 0 0 0 0 0 1 00000004 // lb
0000105C FFE59503 1 1 0 0 0 1 1 0 1 0 0 0 0 1 FFFFFFFE // lh -2
00001060 0085A503 1 1 0 0 0 1 1 0 2 0 0 0 0 1 00000008 // lw
00001064 0005C503 1 1 0 0 0 1 1 0 0 1 0 0 0 1 00000000 // lbu
00001068 0105D503 1 1 0 0 0 1 1 0 1 1 0 0 0 1 00000010 // lhu
0000106C 00E101A3 1 2 0 0 0 1 0 1 0 0 0 0 0 0 00000003 // sb
00001070 FEE11E23 1 2 0 0 0 1 0 1 1 0 0 0 0 0 FFFFFFFC // sh -4
00001074 04E12023 1 2 0 0 0 1 0 1 2 0 0 0 0 0 00000040 // sw
00001078 00208863 1 3 0 1 0 0 0 0 0 0 0 1 0 0 00000010 // beq +16
0000107C FE209CE3 1 3 0 1 0 0 0 0 0 0 0 2 0 0 FFFFFFF8 // bne -8
00001080 0020C0E3 1 3 2 1 0 0 0 0 0 0 0 2 0 0 00000800 // blt +2048
00001084 0020D263 1 3 2 1 0 0 0 0 0 0 0 1 0 0 00000004 // bge +4
00001088 8020E063 1 3 3 1 0 0 0 0 0 0 0 2 0 0 FFFFF000 // bltu -4096
0000108C 7E20F063 1 3 3 1 0 0 0 0 0 0 0 1 0 0 000007E0 // bgeu
00001090 008000EF 1 5 0 0 1 2 0 0 0 0 0 3 0 1 00000008 // jal +8
00001094 FFFFF06F 1 5 0 0 1 2 0 0 0 0 0 3 0 1 FFFFFFFE // jal -2
00001098 000011EF 1 5 0 0 1 2 0 0 0 0 0 3 0 1 00001000 // jal +4096
0000109C 00C280E7 1 1 0 0 1 2 0 0 0 0 0 3 1 1 0000000C // jalr
000010A0 00C290E7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00000000 // jalr bad funct3
000010A4 0FF0000F 1 0 0 0 0 0 0 0 0 0 0 0 0 0 00000000 // fence
000010A8 0000100F 1 0 0 0 0 0 0 0 0 0 1 0 0 0 00000000 // fence.i
000010AC 00000073 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00000000 // ecall
000010B0 300110F3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00000000 // csrrw
000010B4 003100FF 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00000000 // unused opcode
000010B8 023100B3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00000000 // bad funct7

// ==== rv32_decode_stage.f ====
rtl/rv32_pkg.sv
rtl/rv32_pipe_reg.sv
rtl/rv32_control_unit.sv
rtl/rv32_imm_gen.sv
rtl/rv32_decode_stage.sv
verif/rv32_decode_stage_tb.sv
